/* logic/rab_cfg_cfg.svh */
// widths, depths and register map of the RAB config port; NUM_REGS must be a power of two
`ifndef RAB_CFG_CFG_SVH
`define RAB_CFG_CFG_SVH

// bus
`define RAB_AXI_DATA_W      64
`define RAB_AXI_ADDR_W      32

// L1 slices, four registers per slice
`define RAB_NUM_REGS        16
`define RAB_VA_W            32
`define RAB_PA_W            40
`define RAB_NUM_FLAGS       4

// miss handling
`define RAB_META_W          10
`define RAB_MH_DEPTH        16

// register map
`define RAB_CONFIG_SIZE     'h20   // slice 0 lies below this and is not reachable
`define RAB_REG_ADDR_LSB    3      // 64-bit registers
`define RAB_MH_ADDR_OFS     'h00
`define RAB_MH_META_OFS     'h08
`define RAB_MH_CTRL_OFS     'h0C
`define RAB_META_EMPTY_BIT  31

`endif

/* logic/axi_lite_pkg.sv */
// AXI4-Lite bus types for the config port; only the OKAY response is ever produced
`include "rab_cfg_cfg.svh"

package axi_lite_pkg;

  // address and data as seen on the bus
  typedef logic [`RAB_AXI_ADDR_W-1:0]   axi_addr_t;
  typedef logic [`RAB_AXI_DATA_W-1:0]   axi_data_t;

  // one strobe bit per data byte
  typedef logic [`RAB_AXI_DATA_W/8-1:0] axi_strb_t;

  typedef logic [1:0] axi_resp_t;

  localparam axi_resp_t RESP_OKAY = 2'b00;

endpackage

/* logic/rab_pkg.sv */
// RAB slice and miss types; field widths come from the cfg header and must not exceed 64 bits
`include "rab_cfg_cfg.svh"

package rab_pkg;

  // slice fields
  typedef logic [`RAB_VA_W-1:0]      vaddr_t;     // also the address FIFO entry
  typedef logic [`RAB_PA_W-1:0]      paddr_t;
  typedef logic [`RAB_NUM_FLAGS-1:0] slice_flags_t;

  // miss metadata, the meta FIFO entry
  typedef logic [`RAB_META_W-1:0] miss_meta_t;

  typedef logic [$clog2(`RAB_NUM_REGS)-1:0] reg_idx_t;

  // field held by a register, low two index bits
  typedef enum logic [1:0] {
    KIND_VA_START = 2'b00,
    KIND_VA_END   = 2'b01,
    KIND_PA       = 2'b10,
    KIND_FLAGS    = 2'b11
  } slice_reg_kind_e;

  // miss handler control register
  typedef struct packed {
    logic allow_multi_hit;  // bit 1
    logic fifo_disable;     // bit 0
  } mh_ctrl_t;

endpackage

/* logic/miss_fifo.sv */
// FIFO with one cycle from push to output; push while full and pop while empty are dropped
`timescale 1ns/1ps

module miss_fifo #(
  parameter type         entry_t = logic,
  parameter int unsigned DEPTH   = 16
) (
  input  logic   Clk_CI,
  input  logic   Rst_RBI,
  input  logic   push_i,
  input  entry_t data_i,
  input  logic   pop_i,
  output entry_t data_o,
  output logic   full_o,
  output logic   empty_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  entry_t           mem_q [DEPTH];
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W:0]   count_q;
  logic [PTR_W:0]   wr_sum;
  logic [PTR_W-1:0] wr_idx;
  logic             push_ok, pop_ok;

  assign full_o  = count_q == (PTR_W+1)'(DEPTH);
  assign empty_o = count_q == '0;
  assign push_ok = push_i & ~full_o;
  assign pop_ok  = pop_i & ~empty_o;

  // write slot follows the head by count entries
  assign wr_sum = {1'b0, rd_ptr_q} + count_q;
  assign wr_idx = (wr_sum >= (PTR_W+1)'(DEPTH)) ? PTR_W'(wr_sum - (PTR_W+1)'(DEPTH))
                                                : PTR_W'(wr_sum);

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (pop_ok)
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH-1)) ? '0 : rd_ptr_q + 1'b1;
      count_q <= count_q + (PTR_W+1)'(push_ok) - (PTR_W+1)'(pop_ok);
    end
  end

  always_ff @(posedge Clk_CI)
  begin
    if (push_ok)
      mem_q[wr_idx] <= data_i;
  end

  always_comb
  begin
    if (empty_o)
      data_o = '0;  // no stale head
    else
      data_o = mem_q[rd_ptr_q];
  end

  a_count_max: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    count_q <= (PTR_W+1)'(DEPTH));

endmodule

/* logic/cfg_axi_lite_slave.sv */
// AXI4-Lite slave, one write and one read outstanding at most, responses always OKAY
`timescale 1ns/1ps
`include "rab_cfg_cfg.svh"

module cfg_axi_lite_slave
  import axi_lite_pkg::*;
(
  input  logic      Clk_CI,
  input  logic      Rst_RBI,
  // bus
  input  axi_addr_t awaddr_i,
  input  logic      awvalid_i,
  output logic      awready_o,
  input  axi_data_t wdata_i,
  input  axi_strb_t wstrb_i,
  input  logic      wvalid_i,
  output logic      wready_o,
  output axi_resp_t bresp_o,
  output logic      bvalid_o,
  input  logic      bready_i,
  input  axi_addr_t araddr_i,
  input  logic      arvalid_i,
  output logic      arready_o,
  output axi_data_t rdata_o,
  output axi_resp_t rresp_o,
  output logic      rvalid_o,
  input  logic      rready_i,
  // register side
  output logic      slice_wr_o,
  output logic      mh_wr_o,
  output axi_addr_t wr_addr_o,
  output axi_data_t wr_data_o,
  output axi_strb_t wr_strb_o,
  output axi_addr_t rd_addr_o,
  input  axi_data_t slice_rdata_i,
  input  axi_data_t mh_rdata_i,
  output logic      mh_rd_ack_o
);

  axi_addr_t awaddr_q, araddr_q;
  axi_data_t wdata_q;
  axi_strb_t wstrb_q;
  axi_data_t rdata_q;
  logic      aw_done_q, aw_done_dly_q;
  logic      w_done_q, w_done_dly_q;
  logic      b_done_q;
  logic      ar_done_q, r_done_q;
  logic      wr_stb;
  logic      wr_in_cfg, rd_in_cfg;

  // one pulse once both AW and W are in, whichever came last
  assign wr_stb = (aw_done_q & ~aw_done_dly_q & w_done_q) |
                  (w_done_q & ~w_done_dly_q & aw_done_q);

  assign wr_in_cfg = awaddr_q < axi_addr_t'(`RAB_CONFIG_SIZE);
  assign rd_in_cfg = araddr_q < axi_addr_t'(`RAB_CONFIG_SIZE);

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      awready_o     <= 1'b1;
      wready_o      <= 1'b1;
      aw_done_q     <= 1'b0;
      w_done_q      <= 1'b0;
      aw_done_dly_q <= 1'b0;
      w_done_dly_q  <= 1'b0;
    end
    else
    begin
      aw_done_dly_q <= aw_done_q;
      w_done_dly_q  <= w_done_q;
      if (awready_o && awvalid_i)
      begin
        awready_o <= 1'b0;
        aw_done_q <= 1'b1;
      end
      else if (aw_done_q && b_done_q)  // reopen after the response
      begin
        awready_o <= 1'b1;
        aw_done_q <= 1'b0;
      end
      if (wready_o && wvalid_i)
      begin
        wready_o <= 1'b0;
        w_done_q <= 1'b1;
      end
      else if (w_done_q && b_done_q)
      begin
        wready_o <= 1'b1;
        w_done_q <= 1'b0;
      end
    end
  end

  // write response
  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      bvalid_o <= 1'b0;
      b_done_q <= 1'b0;
    end
    else if (aw_done_q && w_done_q && !b_done_q)
    begin
      if (!bvalid_o)
        bvalid_o <= 1'b1;  // raised at the end of the strobe cycle
      else if (bready_i)
      begin
        bvalid_o <= 1'b0;
        b_done_q <= 1'b1;
      end
    end
    else
    begin
      bvalid_o <= 1'b0;
      b_done_q <= 1'b0;
    end
  end

  // AR and R channels
  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      arready_o <= 1'b1;
      ar_done_q <= 1'b0;
      rvalid_o  <= 1'b0;
      r_done_q  <= 1'b0;
    end
    else
    begin
      if (arready_o && arvalid_i)
      begin
        arready_o <= 1'b0;
        ar_done_q <= 1'b1;
      end
      else if (ar_done_q && r_done_q)
      begin
        arready_o <= 1'b1;
        ar_done_q <= 1'b0;
      end
      if (ar_done_q && !r_done_q)
      begin
        if (!rvalid_o)
          rvalid_o <= 1'b1;
        else if (rready_i)
        begin
          rvalid_o <= 1'b0;
          r_done_q <= 1'b1;
        end
      end
      else
      begin
        rvalid_o <= 1'b0;
        r_done_q <= 1'b0;
      end
    end
  end

  // latched request payload
  always_ff @(posedge Clk_CI)
  begin
    if (awready_o && awvalid_i)
      awaddr_q <= awaddr_i;
    if (wready_o && wvalid_i)
    begin
      wdata_q <= wdata_i;
      wstrb_q <= wstrb_i;
    end
    if (arready_o && arvalid_i)
      araddr_q <= araddr_i;
    if (ar_done_q && !r_done_q && !rvalid_o)  // sampled as rvalid rises
      rdata_q <= rd_in_cfg ? mh_rdata_i : slice_rdata_i;
  end

  assign slice_wr_o  = wr_stb & ~wr_in_cfg;
  assign mh_wr_o     = wr_stb & wr_in_cfg;
  assign wr_addr_o   = awaddr_q;
  assign wr_data_o   = wdata_q;
  assign wr_strb_o   = wstrb_q;
  assign rd_addr_o   = araddr_q;
  assign rdata_o     = rdata_q;
  assign mh_rd_ack_o = rvalid_o & rready_i & rd_in_cfg;  // FIFO pop
  assign bresp_o     = RESP_OKAY;
  assign rresp_o     = RESP_OKAY;

  a_bvalid_hold: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    bvalid_o && !bready_i |=> bvalid_o);

  a_rdata_stable: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o));

endmodule

/* logic/slice_cfg_regs.sv */
// L1 slice registers, four per slice; bits beyond each field's width always read as zero
`timescale 1ns/1ps
`include "rab_cfg_cfg.svh"

module slice_cfg_regs
  import axi_lite_pkg::*;
  import rab_pkg::*;
(
  input  logic                             Clk_CI,
  input  logic                             Rst_RBI,
  input  logic                             wr_i,
  input  reg_idx_t                         wr_idx_i,
  input  axi_data_t                        wr_data_i,
  input  axi_strb_t                        wr_strb_i,
  input  reg_idx_t                         rd_idx_i,
  output axi_data_t                        rd_data_o,
  output axi_data_t [`RAB_NUM_REGS-1:0]    slice_cfg_o
);

  localparam int unsigned NUM_BYTES = `RAB_AXI_DATA_W / 8;

  axi_data_t [`RAB_NUM_REGS-1:0] regs_q;
  slice_reg_kind_e               wr_kind;
  axi_data_t                     wr_mask;

  // ones over the field held by a register of this kind
  function automatic axi_data_t field_mask(slice_reg_kind_e kind);
    axi_data_t mask;
    case (kind)
      KIND_PA:    mask = axi_data_t'({$bits(paddr_t){1'b1}});
      KIND_FLAGS: mask = axi_data_t'({$bits(slice_flags_t){1'b1}});
      default:    mask = axi_data_t'({$bits(vaddr_t){1'b1}});  // both VA registers
    endcase
    return mask;
  endfunction

  assign wr_kind = slice_reg_kind_e'(wr_idx_i[1:0]);
  assign wr_mask = field_mask(wr_kind);

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
      regs_q <= '0;
    else if (wr_i)
    begin
      for (int b = 0; b < NUM_BYTES; b++)
      begin
        if (wr_mask[b*8 +: 8] == 8'h00)
          regs_q[wr_idx_i][b*8 +: 8] <= 8'h00;  // byte above the field
        else if (wr_strb_i[b])
          regs_q[wr_idx_i][b*8 +: 8] <= wr_data_i[b*8 +: 8] & wr_mask[b*8 +: 8];
      end
    end
  end

  // flags byte is only partly inside the field, so mask again on the way out
  for (genvar j = 0; j < `RAB_NUM_REGS; j++)
  begin : g_out
    assign slice_cfg_o[j] = regs_q[j] & field_mask(slice_reg_kind_e'(2'(j % 4)));
  end

  assign rd_data_o = slice_cfg_o[rd_idx_i];

  a_wr_idx_range: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    wr_i |-> int'(wr_idx_i) < `RAB_NUM_REGS);

endmodule

/* logic/miss_handler.sv */
// miss FIFOs and control register; a miss wins over an AXI push in the same cycle
`timescale 1ns/1ps
`include "rab_cfg_cfg.svh"

module miss_handler
  import axi_lite_pkg::*;
  import rab_pkg::*;
(
  input  logic                                Clk_CI,
  input  logic                                Rst_RBI,
  input  logic                                miss_i,
  input  vaddr_t                              miss_addr_i,
  input  miss_meta_t                          miss_meta_i,
  input  logic                                wr_i,
  input  logic [$clog2(`RAB_CONFIG_SIZE)-1:0] wr_ofs_i,
  input  axi_data_t                           wr_data_i,
  input  logic [$clog2(`RAB_CONFIG_SIZE)-1:0] rd_ofs_i,
  input  logic                                rd_ack_i,
  output axi_data_t                           rd_data_o,
  output logic                                mh_fifo_full_o,
  output logic                                allow_multi_hit_o
);

  localparam int unsigned OFS_W = $clog2(`RAB_CONFIG_SIZE);
  localparam logic [OFS_W-1:0] ADDR_OFS = OFS_W'(`RAB_MH_ADDR_OFS);
  localparam logic [OFS_W-1:0] META_OFS = OFS_W'(`RAB_MH_META_OFS);
  localparam logic [OFS_W-1:0] CTRL_OFS = OFS_W'(`RAB_MH_CTRL_OFS);

  mh_ctrl_t   ctrl_q;
  vaddr_t     addr_din, addr_head;
  miss_meta_t meta_din, meta_head;
  logic       addr_push, addr_pop, addr_full, addr_empty;
  logic       meta_push, meta_pop, meta_full, meta_empty;

  always_comb
  begin
    addr_push = 1'b0;
    meta_push = 1'b0;
    addr_din  = miss_addr_i;
    meta_din  = miss_meta_i;
    if (!ctrl_q.fifo_disable)
    begin
      if (miss_i)
      begin
        addr_push = 1'b1;
        meta_push = 1'b1;
      end
      else if (wr_i && wr_ofs_i == ADDR_OFS)
      begin
        addr_push = 1'b1;
        addr_din  = wr_data_i[$bits(vaddr_t)-1:0];
      end
      else if (wr_i && wr_ofs_i == META_OFS)
      begin
        meta_push = 1'b1;
        meta_din  = wr_data_i[$bits(miss_meta_t)-1:0];
      end
    end
  end

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
      ctrl_q <= '0;
    else if (wr_i && wr_ofs_i == CTRL_OFS)
      ctrl_q <= wr_data_i[$bits(mh_ctrl_t)-1:0];
  end

  assign addr_pop = rd_ack_i & (rd_ofs_i == ADDR_OFS) & ~addr_empty;
  assign meta_pop = rd_ack_i & (rd_ofs_i == META_OFS) & ~meta_empty;

  always_comb
  begin
    rd_data_o = '0;
    case (rd_ofs_i)
      ADDR_OFS: rd_data_o[$bits(vaddr_t)-1:0] = addr_head;
      META_OFS:
      begin
        rd_data_o[`RAB_META_EMPTY_BIT]        = meta_empty;
        rd_data_o[$bits(miss_meta_t)-1:0]     = meta_head;
      end
      CTRL_OFS: rd_data_o[$bits(mh_ctrl_t)-1:0] = ctrl_q;
      default: ;
    endcase
  end

  assign mh_fifo_full_o    = (addr_push & addr_full) | (meta_push & meta_full);
  assign allow_multi_hit_o = ctrl_q.allow_multi_hit;

  miss_fifo #(.entry_t(vaddr_t), .DEPTH(`RAB_MH_DEPTH)) addr_fifo_i (
    .Clk_CI  (Clk_CI),
    .Rst_RBI (Rst_RBI),
    .push_i  (addr_push),
    .data_i  (addr_din),
    .pop_i   (addr_pop),
    .data_o  (addr_head),
    .full_o  (addr_full),
    .empty_o (addr_empty)
  );

  miss_fifo #(.entry_t(miss_meta_t), .DEPTH(`RAB_MH_DEPTH)) meta_fifo_i (
    .Clk_CI  (Clk_CI),
    .Rst_RBI (Rst_RBI),
    .push_i  (meta_push),
    .data_i  (meta_din),
    .pop_i   (meta_pop),
    .data_o  (meta_head),
    .full_o  (meta_full),
    .empty_o (meta_empty)
  );

  // a lost miss must always show up on the overflow flag
  a_miss_overflow: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    miss_i && addr_full && !ctrl_q.fifo_disable |-> mh_fifo_full_o);

endmodule

/* logic/rab_cfg_top.sv */
// RAB config port top; slice 0 sits under the config window and cannot be written
`timescale 1ns/1ps
`include "rab_cfg_cfg.svh"

module rab_cfg_top
  import axi_lite_pkg::*;
  import rab_pkg::*;
(
  input  logic                          Clk_CI,
  input  logic                          Rst_RBI,
  input  axi_addr_t                     awaddr_i,
  input  logic                          awvalid_i,
  output logic                          awready_o,
  input  axi_data_t                     wdata_i,
  input  axi_strb_t                     wstrb_i,
  input  logic                          wvalid_i,
  output logic                          wready_o,
  output axi_resp_t                     bresp_o,
  output logic                          bvalid_o,
  input  logic                          bready_i,
  input  axi_addr_t                     araddr_i,
  input  logic                          arvalid_i,
  output logic                          arready_o,
  output axi_data_t                     rdata_o,
  output axi_resp_t                     rresp_o,
  output logic                          rvalid_o,
  input  logic                          rready_i,
  input  logic                          miss_i,
  input  vaddr_t                        miss_addr_i,
  input  miss_meta_t                    miss_meta_i,
  output axi_data_t [`RAB_NUM_REGS-1:0] l1_cfg_o,
  output logic                          l1_allow_multi_hit_o,
  output logic                          mh_fifo_full_o
);

  logic      slice_wr, mh_wr, mh_rd_ack;
  axi_addr_t wr_addr, rd_addr;
  axi_data_t wr_data, slice_rdata, mh_rdata;
  axi_strb_t wr_strb;

  cfg_axi_lite_slave slave_i (
    .Clk_CI, .Rst_RBI,
    .awaddr_i, .awvalid_i, .awready_o,
    .wdata_i, .wstrb_i, .wvalid_i, .wready_o,
    .bresp_o, .bvalid_o, .bready_i,
    .araddr_i, .arvalid_i, .arready_o,
    .rdata_o, .rresp_o, .rvalid_o, .rready_i,
    .slice_wr_o    (slice_wr),
    .mh_wr_o       (mh_wr),
    .wr_addr_o     (wr_addr),
    .wr_data_o     (wr_data),
    .wr_strb_o     (wr_strb),
    .rd_addr_o     (rd_addr),
    .slice_rdata_i (slice_rdata),
    .mh_rdata_i    (mh_rdata),
    .mh_rd_ack_o   (mh_rd_ack)
  );

  slice_cfg_regs regs_i (
    .Clk_CI, .Rst_RBI,
    .wr_i        (slice_wr),
    .wr_idx_i    (wr_addr[`RAB_REG_ADDR_LSB +: $bits(reg_idx_t)]),
    .wr_data_i   (wr_data),
    .wr_strb_i   (wr_strb),
    .rd_idx_i    (rd_addr[`RAB_REG_ADDR_LSB +: $bits(reg_idx_t)]),
    .rd_data_o   (slice_rdata),
    .slice_cfg_o (l1_cfg_o)
  );

  miss_handler mh_i (
    .Clk_CI, .Rst_RBI,
    .miss_i, .miss_addr_i, .miss_meta_i,
    .wr_i              (mh_wr),
    .wr_ofs_i          (wr_addr[$clog2(`RAB_CONFIG_SIZE)-1:0]),
    .wr_data_i         (wr_data),
    .rd_ofs_i          (rd_addr[$clog2(`RAB_CONFIG_SIZE)-1:0]),
    .rd_ack_i          (mh_rd_ack),
    .rd_data_o         (mh_rdata),
    .mh_fifo_full_o,
    .allow_multi_hit_o (l1_allow_multi_hit_o)
  );

endmodule

/* test/clk_rst_gen.sv */
// 4 ns clock by default; active-low reset released 1 ns after an edge, like the stimulus
`timescale 1ns/1ps

module clk_rst_gen #(
  parameter int unsigned HALF_PERIOD = 2,
  parameter int unsigned RST_CYCLES  = 16
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial
  begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  initial
  begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #1 rst_n_o = 1'b1;  // off the edge
  end

endmodule

/* test/tb_rab_cfg.sv */
// table-driven testbench for rab_cfg_top; needs timing support and assumes empty FIFOs at start
`timescale 1ns/1ps
`include "rab_cfg_cfg.svh"

module tb_rab_cfg
  import axi_lite_pkg::*;
  import rab_pkg::*;
();

  localparam int unsigned RST_CYCLES    = 16;
  localparam int unsigned CYCLES_PER_OP = 40;
  localparam axi_data_t   META_EMPTY    = axi_data_t'(1) << `RAB_META_EMPTY_BIT;

  typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_MISS, OP_CHECK} op_e;

  typedef struct packed {
    op_e        op;
    logic       w_first;  // W before AW
    axi_addr_t  addr;
    axi_data_t  data;
    axi_strb_t  strb;
    vaddr_t     maddr;
    miss_meta_t mmeta;
    axi_data_t  exp;      // read word, or flag in bit 0 for miss and check rows
  } row_t;

  logic                          Clk_CI, Rst_RBI;
  axi_addr_t                     awaddr_i, araddr_i;
  logic                          awvalid_i, wvalid_i, bready_i, arvalid_i, rready_i;
  axi_data_t                     wdata_i, rdata_o;
  axi_strb_t                     wstrb_i;
  logic                          awready_o, wready_o, bvalid_o, arready_o, rvalid_o;
  axi_resp_t                     bresp_o, rresp_o;
  logic                          miss_i;
  vaddr_t                        miss_addr_i;
  miss_meta_t                    miss_meta_i;
  axi_data_t [`RAB_NUM_REGS-1:0] l1_cfg_o;
  logic                          l1_allow_multi_hit_o, mh_fifo_full_o;

  row_t        rows[$];
  axi_data_t   model [`RAB_NUM_REGS];  // expected slice registers
  int unsigned err_cnt = 0;
  integer      seed    = 32'h7503e60e;

  clk_rst_gen #(.HALF_PERIOD(2), .RST_CYCLES(RST_CYCLES)) clk_rst_gen_i (
    .clk_o   (Clk_CI),
    .rst_n_o (Rst_RBI)
  );

  rab_cfg_top rab_cfg_top_inst (.*);

  task automatic next_cycle;
    @(posedge Clk_CI);
    #1;
  endtask

  task automatic report_mismatch(input string name, input axi_data_t exp, input axi_data_t act);
    $display("Error at %0d ns: %s expected %h, got %h", $time, name, exp, act);
    err_cnt++;
  endtask

  task automatic write_row(input axi_addr_t addr, input axi_data_t data, input axi_strb_t strb,
                           input logic w_first);
    row_t r;
    r         = '0;
    r.op      = OP_WRITE;
    r.addr    = addr;
    r.data    = data;
    r.strb    = strb;
    r.w_first = w_first;
    rows.push_back(r);
  endtask

  task automatic read_row(input axi_addr_t addr, input axi_data_t exp);
    row_t r;
    r      = '0;
    r.op   = OP_READ;
    r.addr = addr;
    r.exp  = exp;
    rows.push_back(r);
  endtask

  task automatic miss_row(input vaddr_t maddr, input miss_meta_t mmeta, input logic exp_full);
    row_t r;
    r       = '0;
    r.op    = OP_MISS;
    r.maddr = maddr;
    r.mmeta = mmeta;
    r.exp   = axi_data_t'(exp_full);
    rows.push_back(r);
  endtask

  task automatic check_row(input logic exp_multi_hit);
    row_t r;
    r     = '0;
    r.op  = OP_CHECK;
    r.exp = axi_data_t'(exp_multi_hit);
    rows.push_back(r);
  endtask

  // ones over the field width of a register index
  function automatic axi_data_t field_ones(input int unsigned idx);
    int unsigned width;
    case (idx % 4)
      2:       width = `RAB_PA_W;
      3:       width = `RAB_NUM_FLAGS;
      default: width = `RAB_VA_W;
    endcase
    return (axi_data_t'(1) << width) - axi_data_t'(1);
  endfunction

  function automatic void model_write(input axi_addr_t addr, input axi_data_t data,
                                      input axi_strb_t strb);
    int unsigned idx;
    axi_data_t   byte_en;
    idx = int'(addr[`RAB_REG_ADDR_LSB +: $bits(reg_idx_t)]);
    for (int b = 0; b < $bits(axi_strb_t); b++)
      byte_en[b*8 +: 8] = {8{strb[b]}};
    model[idx] = ((model[idx] & ~byte_en) | (data & byte_en)) & field_ones(idx);
  endfunction

  task automatic offer_address;
    awvalid_i = 1'b1;
    while (!awready_o)
      next_cycle();
    next_cycle();  // handshake edge
    awvalid_i = 1'b0;
  endtask

  task automatic offer_data;
    wvalid_i = 1'b1;
    while (!wready_o)
      next_cycle();
    next_cycle();
    wvalid_i = 1'b0;
  endtask

  task automatic axi_write(input axi_addr_t addr, input axi_data_t data, input axi_strb_t strb,
                           input logic w_first);
    int unsigned delay;
    awaddr_i = addr;
    wdata_i  = data;
    wstrb_i  = strb;
    if (w_first)
    begin
      offer_data();
      offer_address();
    end
    else
    begin
      offer_address();
      offer_data();
    end
    while (!bvalid_o)
      next_cycle();
    if (bresp_o !== RESP_OKAY)
      report_mismatch("bresp_o", axi_data_t'(RESP_OKAY), axi_data_t'(bresp_o));
    delay = $unsigned($random(seed)) % 4;  // back-pressure
    repeat (delay) next_cycle();
    if (bvalid_o !== 1'b1)
      report_mismatch("bvalid_o", axi_data_t'(1), axi_data_t'(bvalid_o));
    bready_i = 1'b1;
    next_cycle();
    bready_i = 1'b0;
  endtask

  task automatic axi_read(input axi_addr_t addr, output axi_data_t data);
    int unsigned delay;
    axi_data_t   first;
    araddr_i  = addr;
    arvalid_i = 1'b1;
    while (!arready_o)
      next_cycle();
    next_cycle();
    arvalid_i = 1'b0;
    while (!rvalid_o)
      next_cycle();
    first = rdata_o;
    delay = $unsigned($random(seed)) % 4;
    repeat (delay) next_cycle();
    if (rvalid_o !== 1'b1)
      report_mismatch("rvalid_o", axi_data_t'(1), axi_data_t'(rvalid_o));
    if (rdata_o !== first)
      report_mismatch("rdata_o (held)", first, rdata_o);
    if (rresp_o !== RESP_OKAY)
      report_mismatch("rresp_o", axi_data_t'(RESP_OKAY), axi_data_t'(rresp_o));
    data     = rdata_o;
    rready_i = 1'b1;
    next_cycle();
    rready_i = 1'b0;
  endtask

  task automatic apply_miss(input vaddr_t maddr, input miss_meta_t mmeta, input logic exp_full);
    miss_i      = 1'b1;
    miss_addr_i = maddr;
    miss_meta_i = mmeta;
    #1;  // flag is combinational
    if (mh_fifo_full_o !== exp_full)
      report_mismatch("mh_fifo_full_o", axi_data_t'(exp_full), axi_data_t'(mh_fifo_full_o));
    next_cycle();
    miss_i = 1'b0;
  endtask

  task automatic check_idle;
    if ({awready_o, wready_o, arready_o} !== 3'b111)
      report_mismatch("aw/w/arready_o", axi_data_t'(3'b111),
                      axi_data_t'({awready_o, wready_o, arready_o}));
    if ({bvalid_o, rvalid_o} !== 2'b00)
      report_mismatch("bvalid_o/rvalid_o", axi_data_t'(0), axi_data_t'({bvalid_o, rvalid_o}));
  endtask

  task automatic check_outputs(input logic exp_multi_hit);
    for (int i = 0; i < `RAB_NUM_REGS; i++)
      if (l1_cfg_o[i] !== model[i])
        report_mismatch($sformatf("l1_cfg_o[%0d]", i), model[i], l1_cfg_o[i]);
    if (l1_allow_multi_hit_o !== exp_multi_hit)
      report_mismatch("l1_allow_multi_hit_o", axi_data_t'(exp_multi_hit),
                      axi_data_t'(l1_allow_multi_hit_o));
    if (mh_fifo_full_o !== 1'b0)
      report_mismatch("mh_fifo_full_o", axi_data_t'(0), axi_data_t'(mh_fifo_full_o));
  endtask

  task automatic build_table;
    // field masking, slice 1 at 0x20
    write_row('h20, '1, 'hFF, 1'b0);
    write_row('h28, '1, 'hFF, 1'b1);
    write_row('h30, '1, 'hFF, 1'b0);
    write_row('h38, '1, 'hFF, 1'b1);
    read_row('h20, 64'h0000_0000_FFFF_FFFF);
    read_row('h28, 64'h0000_0000_FFFF_FFFF);
    read_row('h30, 64'h0000_00FF_FFFF_FFFF);
    read_row('h38, 64'h0000_0000_0000_000F);
    check_row(1'b0);
    // partial strobes
    write_row('h20, 64'h1122_3344_5566_7788, 'h05, 1'b1);
    read_row('h20, 64'h0000_0000_FF66_FF88);
    write_row('h30, 64'hAABB_CCDD_EEFF_0011, 'hF0, 1'b0);
    read_row('h30, 64'h0000_00DD_FFFF_FFFF);
    write_row('h48, 64'h0123_4567_89AB_CDEF, 'h3C, 1'b0);
    read_row('h48, 64'h0000_0000_89AB_0000);
    write_row('h58, 64'hFFFF_FFFF_FFFF_FFA5, 'h01, 1'b1);
    read_row('h58, 64'h0000_0000_0000_0005);
    check_row(1'b0);
    // misses come back in push order
    miss_row(32'h1000_0001, 10'h101, 1'b0);
    miss_row(32'h2000_0002, 10'h202, 1'b0);
    miss_row(32'h3000_0003, 10'h303, 1'b0);
    read_row(`RAB_MH_ADDR_OFS, 64'h1000_0001);
    read_row(`RAB_MH_ADDR_OFS, 64'h2000_0002);
    read_row(`RAB_MH_ADDR_OFS, 64'h3000_0003);
    read_row(`RAB_MH_META_OFS, 64'h101);
    read_row(`RAB_MH_META_OFS, 64'h202);
    read_row(`RAB_MH_META_OFS, 64'h303);
    read_row(`RAB_MH_META_OFS, META_EMPTY);
    // control register
    write_row(`RAB_MH_CTRL_OFS, 64'h2, 'hFF, 1'b0);
    read_row(`RAB_MH_CTRL_OFS, 64'h2);
    check_row(1'b1);
    write_row(`RAB_MH_CTRL_OFS, 64'h1, 'hFF, 1'b1);
    miss_row(32'h4000_0004, 10'h044, 1'b0);  // dropped while disabled
    read_row(`RAB_MH_META_OFS, META_EMPTY);
    read_row(`RAB_MH_CTRL_OFS, 64'h1);
    write_row(`RAB_MH_CTRL_OFS, 64'h0, 'hFF, 1'b0);
    write_row(`RAB_MH_ADDR_OFS, 64'hCAFE_0001, 'hFF, 1'b0);
    write_row(`RAB_MH_ADDR_OFS, 64'hBEEF_0002, 'hFF, 1'b1);
    read_row(`RAB_MH_ADDR_OFS, 64'hCAFE_0001);
    read_row(`RAB_MH_ADDR_OFS, 64'hBEEF_0002);
    // overflow on the seventeenth miss only
    for (int i = 0; i < 17; i++)
      miss_row(vaddr_t'(32'hA000_0000 + i), miss_meta_t'(i), i == 16);
    for (int i = 0; i < 16; i++)
      read_row(`RAB_MH_ADDR_OFS, axi_data_t'(32'hA000_0000 + i));
    check_row(1'b0);
  endtask

  initial
  begin
    row_t      r;
    axi_data_t rd;
    awaddr_i    = '0;
    awvalid_i   = 1'b0;
    wdata_i     = '0;
    wstrb_i     = '0;
    wvalid_i    = 1'b0;
    bready_i    = 1'b0;
    araddr_i    = '0;
    arvalid_i   = 1'b0;
    rready_i    = 1'b0;
    miss_i      = 1'b0;
    miss_addr_i = '0;
    miss_meta_i = '0;
    for (int i = 0; i < `RAB_NUM_REGS; i++)
      model[i] = '0;
    build_table();
    wait (Rst_RBI === 1'b1);
    check_idle();
    check_outputs(1'b0);
    foreach (rows[n])
    begin
      r = rows[n];
      case (r.op)
        OP_WRITE:
        begin
          axi_write(r.addr, r.data, r.strb, r.w_first);
          if (r.addr >= axi_addr_t'(`RAB_CONFIG_SIZE))
            model_write(r.addr, r.data, r.strb);
        end
        OP_READ:
        begin
          axi_read(r.addr, rd);
          if (rd !== r.exp)
            report_mismatch($sformatf("rdata_o @%h", r.addr), r.exp, rd);
        end
        OP_MISS: apply_miss(r.maddr, r.mmeta, r.exp[0]);
        default: check_outputs(r.exp[0]);
      endcase
    end
    next_cycle();
    check_idle();
    $display("%0d rows applied, %0d errors", rows.size(), err_cnt);
    if (err_cnt == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

  // watchdog, sized from the table
  initial
  begin
    #1;
    repeat (rows.size() * CYCLES_PER_OP + RST_CYCLES) @(posedge Clk_CI);
    $display("timeout, the table did not complete within %0d cycles",
             rows.size() * CYCLES_PER_OP + RST_CYCLES);
    $display("TEST FAIL");
    $finish;
  end

endmodule

/* tb.f */
+incdir+logic
logic/axi_lite_pkg.sv
logic/rab_pkg.sv
logic/miss_fifo.sv
logic/cfg_axi_lite_slave.sv
logic/slice_cfg_regs.sv
logic/miss_handler.sv
logic/rab_cfg_top.sv
test/clk_rst_gen.sv
test/tb_rab_cfg.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_rab_cfg
FILELIST  ?= tb.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal
OBJ_DIR   ?= obj_dir
PASS_MSG  := TEST PASS

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# grep decides the exit status of the run
run: compile
	./$(SIM) | tee /dev/stderr | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)
